// File: build.f
logic/audio_pkg.sv
logic/sample_fifo.sv
logic/audio_controller.sv
logic/audio_serializer.sv
logic/audio_top.sv
bench/audio_tb.sv

// File: bench/audio_tb.sv
// Directed testbench for audio_top. CPU inputs change on the falling clock edge.
// The DAC stream is decoded from the pins and compared with the written samples.
// The watchdog time assumes the frame counts and rates used by the tests below.

module audio_tb
	import audio_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLOCK_PERIOD = 20;
	localparam int READY_LIMIT = 1000;
	// frames written per test times 64 times the rate used for them
	localparam longint FRAME_CYCLES = 8 * 64 * 2 + 64 * 1000 + 3 * 64 * 2
		+ (FIFO_DEPTH + 4) * 64 * 4 + FIFO_DEPTH * 64 * 2;
	localparam longint WATCHDOG_NS = (FRAME_CYCLES + 2000) * CLOCK_PERIOD;

	logic i_clock;
	logic i_reset;
	logic i_request;
	logic i_rw;
	logic [3:0] i_address;
	logic [31:0] i_wdata;
	logic [31:0] o_rdata;
	logic o_ready;
	logic o_interrupt;
	logic o_dac_bclk;
	logic o_dac_lrclk;
	logic o_dac_data;

	logic [31:0] expected_q[$];
	logic [31:0] received_q[$];
	logic [31:0] shift_word;
	logic bclk_prev;
	int bit_count;
	int errors;
	int irq_count;
	integer seed;

	audio_top dut0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.o_dac_bclk(o_dac_bclk),
		.o_dac_lrclk(o_dac_lrclk),
		.o_dac_data(o_dac_data)
	);

	initial begin
		i_clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("errors: %0d", errors + 1);
		$display("Result: FAILED");
		$finish;
	end

	// a bclk rise shows up as a change between two falling clock edges
	always @(negedge i_clock) begin
		if (i_reset) begin
			bclk_prev = 1'b0;
			bit_count = 0;
		end else begin
			if (o_dac_bclk && !bclk_prev) begin
				if (o_dac_lrclk != (bit_count >= SAMPLE_WIDTH)) begin
					errors++;
					$display("lrclk has the wrong level at bit %0d of a frame", bit_count);
				end
				shift_word = {shift_word[FRAME_WIDTH-2:0], o_dac_data};
				bit_count++;
				if (bit_count == FRAME_WIDTH) begin
					received_q.push_back(shift_word);
					bit_count = 0;
				end
			end
			bclk_prev = o_dac_bclk;
		end
	end

	always @(negedge i_clock) begin
		if (!i_reset && o_interrupt) begin
			irq_count++;
		end
	end

	task automatic expect_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
		end
	endtask

	// called on a falling edge and returns on the falling edge after o_ready drops
	task automatic bus_access(input logic rw, input logic [3:0] addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int waited;
		waited = 0;
		i_request = 1'b1;
		i_rw = rw;
		i_address = addr;
		i_wdata = data;
		@(negedge i_clock);
		while (!o_ready && waited < READY_LIMIT) begin
			@(negedge i_clock);
			waited++;
		end
		if (!o_ready) begin
			errors++;
			$display("no o_ready within %0d cycles at address %0h", READY_LIMIT, addr);
		end
		rdata = o_rdata;
		i_request = 1'b0;
		@(negedge i_clock);
	endtask

	task automatic cpu_write(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic cpu_read(input logic [3:0] addr, output logic [31:0] data);
		bus_access(1'b0, addr, 32'h0, data);
	endtask

	task automatic write_random_samples(input int n);
		logic [31:0] sample;
		for (int i = 0; i < n; i++) begin
			sample = $random(seed);
			expected_q.push_back(sample);
			cpu_write(ADDR_SAMPLES, sample);
		end
	endtask

	task automatic wait_frames(input int n, input int limit);
		int waited;
		waited = 0;
		while (received_q.size() < n && waited < limit) begin
			@(negedge i_clock);
			waited++;
		end
		if (received_q.size() < n) begin
			errors++;
			$display("only %0d of %0d frames arrived within %0d cycles",
				received_q.size(), n, limit);
		end
	endtask

	task automatic compare_frames;
		if (received_q.size() != expected_q.size()) begin
			errors++;
			$display("received %0d frames but %0d were written",
				received_q.size(), expected_q.size());
		end
		while (received_q.size() > 0 && expected_q.size() > 0) begin
			expect_value("received frame", received_q.pop_front(), expected_q.pop_front());
		end
		received_q.delete();
		expected_q.delete();
	endtask

	task automatic reset_and_rate_test;
		logic [31:0] value;
		cpu_read(ADDR_RATE, value);
		expect_value("rate after reset", value, RESET_RATE);
		cpu_read(ADDR_SAMPLES, value);
		expect_value("count after reset", value, 32'd0);
		cpu_write(ADDR_RATE, 32'h0001_2345);
		cpu_read(ADDR_RATE, value);
		expect_value("rate readback", value, 32'h0001_2345);
		cpu_write(4'h7, 32'hdead_beef);
		cpu_read(4'h7, value);
		expect_value("unmapped read", value, 32'd0);
		cpu_read(ADDR_RATE, value);
		expect_value("rate after unmapped write", value, 32'h0001_2345);
	endtask

	task automatic playback_test;
		logic [31:0] value;
		cpu_write(ADDR_RATE, 32'd2);
		write_random_samples(8);
		wait_frames(8, 8 * 200 + 500);
		compare_frames();
		cpu_read(ADDR_SAMPLES, value);
		expect_value("count after playback", value, 32'd0);
	endtask

	task automatic fill_count_test;
		logic [31:0] value;
		cpu_write(ADDR_RATE, 32'd1000);
		write_random_samples(4);
		cpu_read(ADDR_SAMPLES, value);
		expect_value("count during slow frame", value, 32'd3);
		// only the frame already playing keeps the slow rate
		cpu_write(ADDR_RATE, 32'd2);
		wait_frames(4, 64 * 1000 + 3 * 200 + 1000);
		compare_frames();
	endtask

	task automatic backpressure_test;
		cpu_write(ADDR_RATE, 32'd4);
		write_random_samples(FIFO_DEPTH + 4);
		wait_frames(FIFO_DEPTH + 4, (FIFO_DEPTH + 4) * 300 + 1000);
		compare_frames();
	endtask

	task automatic interrupt_test;
		logic [31:0] value;
		int waited;
		irq_count = 0;
		waited = 0;
		cpu_write(ADDR_RATE, 32'd2);
		write_random_samples(FIFO_DEPTH);
		while (irq_count == 0 && waited < FIFO_DEPTH * 200) begin
			@(negedge i_clock);
			waited++;
		end
		if (irq_count == 0) begin
			errors++;
			$display("no interrupt while the queue drained");
		end
		cpu_read(ADDR_SAMPLES, value);
		expect_value("count at or below low water", 32'(value <= LOW_WATER), 32'd1);
		wait_frames(FIFO_DEPTH, FIFO_DEPTH * 200 + 1000);
		compare_frames();
		expect_value("interrupt pulses", irq_count, 32'd1);
	endtask

	initial begin
		seed = 77594;
		errors = 0;
		irq_count = 0;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = 4'h0;
		i_wdata = 32'h0;
		repeat (8) @(negedge i_clock);
		i_reset = 1'b0;
		reset_and_rate_test();
		playback_test();
		fill_count_test();
		backpressure_test();
		interrupt_test();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: logic/audio_top.sv
// Audio playback subsystem: CPU register block, sample queue and DAC serializer.
// The DAC pins run from i_clock, with no clock-domain crossing.

module audio_top
	import audio_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	// CPU side
	input logic i_request,
	input logic i_rw,
	input logic [3:0] i_address,
	input logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt,

	// DAC pins
	output logic o_dac_bclk,
	output logic o_dac_lrclk,
	output logic o_dac_data
);

	logic busy;
	logic [31:0] rate;
	logic [SAMPLE_WIDTH-1:0] sample_left;
	logic [SAMPLE_WIDTH-1:0] sample_right;
	logic sample_strobe;

	audio_controller controller0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.i_busy(busy),
		.o_rate(rate),
		.o_sample_left(sample_left),
		.o_sample_right(sample_right),
		.o_sample_strobe(sample_strobe)
	);

	audio_serializer serializer0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rate(rate),
		.i_sample_left(sample_left),
		.i_sample_right(sample_right),
		.i_sample_strobe(sample_strobe),
		.o_busy(busy),
		.o_dac_bclk(o_dac_bclk),
		.o_dac_lrclk(o_dac_lrclk),
		.o_dac_data(o_dac_data)
	);

endmodule

// File: logic/audio_serializer.sv
// Left-justified stereo output to an external DAC, bclk and lrclk divided from i_clock.
// A frame is 32 bit periods, 64 times the rate in cycles; a rate of 0 acts as 1.
// Strobes arriving while busy are ignored. Pins rest low between frames.

module audio_serializer
	import audio_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	input logic [31:0] i_rate,
	input logic [SAMPLE_WIDTH-1:0] i_sample_left,
	input logic [SAMPLE_WIDTH-1:0] i_sample_right,
	input logic i_sample_strobe,
	output logic o_busy,

	output logic o_dac_bclk,
	output logic o_dac_lrclk,
	output logic o_dac_data
);

	localparam int BIT_WIDTH = $clog2(FRAME_WIDTH);

	logic [FRAME_WIDTH-1:0] shift_reg;
	logic [31:0] rate_q;
	logic [31:0] div_count;
	logic [BIT_WIDTH-1:0] bit_index;
	logic half_done;
	logic last_bit;

	// end of one half period of bclk
	assign half_done = (div_count == rate_q - 1'b1);
	assign last_bit = (bit_index == BIT_WIDTH'(FRAME_WIDTH - 1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_busy <= 1'b0;
			o_dac_bclk <= 1'b0;
			div_count <= '0;
			bit_index <= '0;
		end else if (!o_busy) begin
			if (i_sample_strobe) begin
				o_busy <= 1'b1;
				o_dac_bclk <= 1'b0;
				div_count <= '0;
				bit_index <= '0;
			end
		end else if (half_done) begin
			div_count <= '0;
			o_dac_bclk <= !o_dac_bclk;
			// on a bclk fall move to the next bit or finish the frame
			if (o_dac_bclk) begin
				if (last_bit) begin
					o_busy <= 1'b0;
				end else begin
					bit_index <= bit_index + 1'b1;
				end
			end
		end else begin
			div_count <= div_count + 1'b1;
		end
	end

	// sample and rate are latched once per frame
	always_ff @(posedge i_clock) begin
		if (!o_busy && i_sample_strobe) begin
			shift_reg <= {i_sample_left, i_sample_right};
			rate_q <= (i_rate == '0) ? 32'd1 : i_rate;
		end else if (o_busy && half_done && o_dac_bclk) begin
			shift_reg <= {shift_reg[FRAME_WIDTH-2:0], 1'b0};
		end
	end

	// msb first and the upper bit index selects the right channel
	assign o_dac_data = o_busy && shift_reg[FRAME_WIDTH-1];
	assign o_dac_lrclk = o_busy && bit_index[BIT_WIDTH-1];

endmodule

// File: logic/audio_controller.sv
// CPU register block and sample queue owner for the playback path.
// A CPU write to ADDR_SAMPLES while the queue is full is held off until room frees up.
// One queue word is handed to the serializer per frame.

module audio_controller
	import audio_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	// CPU side
	input logic i_request,
	input logic i_rw,
	input logic [3:0] i_address,
	input logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt,

	// serializer side
	input logic i_busy,
	output logic [31:0] o_rate,
	output logic [SAMPLE_WIDTH-1:0] o_sample_left,
	output logic [SAMPLE_WIDTH-1:0] o_sample_right,
	output logic o_sample_strobe
);

	logic access_start;
	logic fifo_write;
	logic fifo_read;
	logic fifo_empty;
	logic fifo_full;
	logic [FRAME_WIDTH-1:0] fifo_rdata;
	logic [COUNT_WIDTH-1:0] fifo_count;
	logic read_waiting;
	logic [1:0] above_history;

	sample_fifo #(
		.DEPTH(FIFO_DEPTH)
	) fifo0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(fifo_write),
		.i_wdata(i_wdata),
		.i_read(fifo_read),
		.o_rdata(fifo_rdata),
		.o_empty(fifo_empty),
		.o_full(fifo_full),
		.o_count(fifo_count)
	);

	assign o_sample_left = fifo_rdata[FRAME_WIDTH-1:SAMPLE_WIDTH];
	assign o_sample_right = fifo_rdata[SAMPLE_WIDTH-1:0];

	// a pending request not yet acknowledged
	assign access_start = i_request && !o_ready;

	// push lands on the same edge that raises o_ready
	assign fifo_write = access_start && i_rw && (i_address == ADDR_SAMPLES) && !fifo_full;

	// drain only when the serializer is idle and nothing is in flight
	assign fifo_read = !i_busy && !fifo_empty && !read_waiting;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_rate <= RESET_RATE;
		end else if (access_start) begin
			if (i_rw) begin
				case (i_address)
					ADDR_SAMPLES: o_ready <= !fifo_full;
					ADDR_RATE: begin
						o_rate <= i_wdata;
						o_ready <= 1'b1;
					end
					default: o_ready <= 1'b1;
				endcase
			end else begin
				o_ready <= 1'b1;
			end
		end else if (!i_request) begin
			o_ready <= 1'b0;
		end
	end

	// the count is read as seen at the sampling edge
	always_ff @(posedge i_clock) begin
		if (access_start && !i_rw) begin
			case (i_address)
				ADDR_SAMPLES: o_rdata <= 32'(fifo_count);
				ADDR_RATE: o_rdata <= o_rate;
				default: o_rdata <= '0;
			endcase
		end
	end

	// waiting stays set from the read until busy shows up
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_sample_strobe <= 1'b0;
			read_waiting <= 1'b0;
		end else begin
			o_sample_strobe <= fifo_read;
			if (fifo_read) begin
				read_waiting <= 1'b1;
			end else if (i_busy) begin
				read_waiting <= 1'b0;
			end
		end
	end

	// falling crossing of the low-water mark
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			above_history <= 2'b00;
			o_interrupt <= 1'b0;
		end else begin
			above_history <= {above_history[0], fifo_count > COUNT_WIDTH'(LOW_WATER)};
			o_interrupt <= (above_history == 2'b10);
		end
	end

endmodule

// File: logic/sample_fifo.sv
// Circular sample queue with a registered read port, block RAM style.
// o_rdata holds the word one cycle after i_read.
// DEPTH must be a power of two, at least 2 and at most FIFO_DEPTH.
// No protection: the caller never reads when empty or writes when full.

module sample_fifo
	import audio_pkg::*;
#(
	parameter int DEPTH = FIFO_DEPTH
) (
	input logic i_clock,
	input logic i_reset,

	input logic i_write,
	input logic [FRAME_WIDTH-1:0] i_wdata,

	input logic i_read,
	output logic [FRAME_WIDTH-1:0] o_rdata,

	output logic o_empty,
	output logic o_full,
	output logic [COUNT_WIDTH-1:0] o_count
);

	localparam int PTR_WIDTH = $clog2(DEPTH);

	logic [FRAME_WIDTH-1:0] mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [COUNT_WIDTH-1:0] count;

	// storage and read port carry no reset
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[wr_ptr] <= i_wdata;
		end
		if (i_read) begin
			o_rdata <= mem[rd_ptr];
		end
	end

	// pointers wrap naturally since DEPTH is a power of two
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
		end else begin
			case ({i_write, i_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign o_count = count;
	assign o_empty = (count == '0);
	assign o_full = (count == COUNT_WIDTH'(DEPTH));

endmodule

// File: logic/audio_pkg.sv
// Shared constants of the audio playback path.
// FIFO_DEPTH must be a power of two; COUNT_WIDTH follows from it.
// Register addresses are 4 bits wide to match the CPU address bus.

package audio_pkg;

	// one channel and one packed stereo word (left in the upper half)
	localparam int SAMPLE_WIDTH = 16;
	localparam int FRAME_WIDTH = 2 * SAMPLE_WIDTH;

	// sample queue
	localparam int FIFO_DEPTH = 64;
	localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH) + 1;

	// interrupt when the queue drains to this fill level or below
	localparam int LOW_WATER = FIFO_DEPTH / 2;

	// CPU register map
	localparam logic [3:0] ADDR_SAMPLES = 4'h0;
	localparam logic [3:0] ADDR_RATE = 4'h1;

	// i_clock cycles per half period of the bit clock
	localparam logic [31:0] RESET_RATE = 32'd8;

endpackage
